//--- common/soc_map_pkg.sv
// address map of the SoC; both regions must be aligned to their own span
`default_nettype none

package soc_map_pkg;

  import tcb_pkg::*;

  // data memory, word address bits
  localparam adr_t        MEM_BASE = 32'h8000_0000;
  localparam int unsigned MEM_ADR  = 10;
  // span in bytes, 4 KiB
  localparam int unsigned MEM_SPAN = 4 << MEM_ADR;

  // GPIO controller
  localparam adr_t        GPIO_BASE = 32'h8000_4000;
  localparam int unsigned GPIO_SPAN = 64;
  localparam int unsigned GW        = 32;

  typedef logic [GW-1:0] gpio_t;

  // register offsets inside the GPIO window
  localparam adr_t GPIO_OUT = 32'h0;
  localparam adr_t GPIO_ENA = 32'h4;
  localparam adr_t GPIO_INP = 32'h8;

  // decoder targets
  typedef enum logic [1:0] {
    TGT_MEM,
    TGT_GPIO,
    TGT_NONE
  } tgt_e;

endpackage : soc_map_pkg

`default_nettype wire

//--- common/tcb_pkg.sv
// bus types for a 32-bit little-endian bus, one request per cycle, no ready and no back-pressure
`default_nettype none

package tcb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // basic widths
  ////////////////////////////////////////////////////////////////////////////

  // byte address
  typedef logic [31:0] adr_t;
  // data word
  typedef logic [31:0] dat_t;
  // log2 of access size in bytes
  typedef logic [1:0]  siz_t;
  // one enable per byte lane
  typedef logic [3:0]  ben_t;

  // access size encodings, 3 is illegal
  localparam siz_t SIZ_B = 2'd0;
  localparam siz_t SIZ_H = 2'd1;
  localparam siz_t SIZ_W = 2'd2;

  ////////////////////////////////////////////////////////////////////////////
  // request and response
  ////////////////////////////////////////////////////////////////////////////

  // request payload, qualified by the separate vld strobe
  typedef struct packed {
    logic wen;
    adr_t adr;
    siz_t siz;
    dat_t wdt;
  } tcb_req_t;

  // response, one cycle after the request
  typedef struct packed {
    dat_t rdt;
    logic err;
  } tcb_rsp_t;

endpackage : tcb_pkg

`default_nettype wire

//--- compile.f
common/tcb_pkg.sv
common/soc_map_pkg.sv
logic/tcb_decoder_demux.sv
mem/soc_memory.sv
gpio/tcb_gpio.sv
logic/soc_top.sv
verif/soc_tb.sv

//--- gpio/tcb_gpio.sv
// word access only at OUT, ENA and INP; inputs seen 2 cycles late; writes to INP are dropped
`default_nettype none

module tcb_gpio
  import tcb_pkg::*;
  import soc_map_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n,
  // bus
  input  wire logic     vld,
  input  wire tcb_req_t req,
  output tcb_rsp_t      rsp,
  // pins
  input  wire gpio_t    gpio_i,
  output gpio_t         gpio_o,
  output gpio_t         gpio_e
);

  adr_t  ofs;
  logic  legal;
  dat_t  rdm;
  // input synchronizer stages
  gpio_t sync_0;
  gpio_t sync_1;

  ////////////////////////////////////////////////////////////////////////////
  // register decode
  ////////////////////////////////////////////////////////////////////////////

  // offset inside the window
  assign ofs = req.adr & adr_t'(GPIO_SPAN - 1);

  assign legal = (req.siz == SIZ_W) &&
                 ((ofs == GPIO_OUT) || (ofs == GPIO_ENA) || (ofs == GPIO_INP));

  // read mux
  always_comb begin
    case (ofs)
      GPIO_OUT: rdm = dat_t'(gpio_o);
      GPIO_ENA: rdm = dat_t'(gpio_e);
      GPIO_INP: rdm = dat_t'(sync_1);
      default:  rdm = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // pin registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gpio_o <= '0;
      gpio_e <= '0;
    end else if (vld && req.wen && legal) begin
      if (ofs == GPIO_OUT) begin
        gpio_o <= gpio_t'(req.wdt);
      end
      if (ofs == GPIO_ENA) begin
        gpio_e <= gpio_t'(req.wdt);
      end
    end
  end

  // two flops against metastability
  always_ff @(posedge clk) begin
    sync_0 <= gpio_i;
    sync_1 <= sync_0;
  end

  // response register
  always_ff @(posedge clk) begin
    if (vld) begin
      rsp.err <= !legal;
      rsp.rdt <= (legal && !req.wen) ? rdm : '0;
    end
  end

  // enables drive pads, so never unknown once out of reset
  assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(gpio_e));

endmodule : tcb_gpio

`default_nettype wire

//--- logic/soc_top.sv
// bus fabric without core; manager port answers every request exactly one cycle later
`default_nettype none

module soc_top
  import tcb_pkg::*;
  import soc_map_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n,
  // manager port
  input  wire logic     vld,
  input  wire tcb_req_t req,
  output tcb_rsp_t      rsp,
  output logic          rsp_vld,
  // GPIO pins
  input  wire gpio_t    gpio_i,
  output gpio_t         gpio_o,
  output gpio_t         gpio_e
);

  ////////////////////////////////////////////////////////////////////////////
  // interconnect
  ////////////////////////////////////////////////////////////////////////////

  logic     mem_vld;
  logic     gpio_vld;
  tcb_rsp_t mem_rsp;
  tcb_rsp_t gpio_rsp;

  // memory and GPIO split
  tcb_decoder_demux dec (
    .clk      (clk),
    .rst_n    (rst_n),
    .vld      (vld),
    .req      (req),
    .rsp      (rsp),
    .rsp_vld  (rsp_vld),
    .mem_vld  (mem_vld),
    .gpio_vld (gpio_vld),
    .mem_rsp  (mem_rsp),
    .gpio_rsp (gpio_rsp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // targets
  ////////////////////////////////////////////////////////////////////////////

  // data memory
  soc_memory mem (
    .clk (clk),
    .vld (mem_vld),
    .req (req),
    .rsp (mem_rsp)
  );

  // GPIO controller
  tcb_gpio gpio (
    .clk    (clk),
    .rst_n  (rst_n),
    .vld    (gpio_vld),
    .req    (req),
    .rsp    (gpio_rsp),
    .gpio_i (gpio_i),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e)
  );

endmodule : soc_top

`default_nettype wire

//--- logic/tcb_decoder_demux.sv
// targets must answer exactly one cycle after their strobe; unmapped space gets err with rdt zero
`default_nettype none

module tcb_decoder_demux
  import tcb_pkg::*;
  import soc_map_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n,
  // manager side
  input  wire logic     vld,
  input  wire tcb_req_t req,
  output tcb_rsp_t      rsp,
  output logic          rsp_vld,
  // target strobes
  output logic          mem_vld,
  output logic          gpio_vld,
  // target responses
  input  wire tcb_rsp_t mem_rsp,
  input  wire tcb_rsp_t gpio_rsp
);

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  tgt_e tgt;
  // target of the request in flight
  tgt_e sel;

  // regions are span aligned, so a masked compare is enough
  always_comb begin
    if ((req.adr & ~adr_t'(MEM_SPAN - 1)) == MEM_BASE) begin
      tgt = TGT_MEM;
    end else if ((req.adr & ~adr_t'(GPIO_SPAN - 1)) == GPIO_BASE) begin
      tgt = TGT_GPIO;
    end else begin
      tgt = TGT_NONE;
    end
  end

  // strobe goes to the selected target only
  assign mem_vld  = vld && (tgt == TGT_MEM);
  assign gpio_vld = vld && (tgt == TGT_GPIO);

  ////////////////////////////////////////////////////////////////////////////
  // response path
  ////////////////////////////////////////////////////////////////////////////

  // selection and strobe held for one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
      sel     <= TGT_NONE;
    end else begin
      rsp_vld <= vld;
      if (vld) begin
        sel <= tgt;
      end
    end
  end

  // response mux
  always_comb begin
    case (sel)
      TGT_MEM:  rsp = mem_rsp;
      TGT_GPIO: rsp = gpio_rsp;
      // decoder answers unmapped space itself
      default:  rsp = '{rdt: '0, err: 1'b1};
    endcase
  end

  // the selected target must have answered in the cycle after its strobe
  assert property (@(posedge clk) disable iff (!rst_n)
    rsp_vld |-> !$isunknown(rsp.err));

endmodule : tcb_decoder_demux

`default_nettype wire

//--- mem/soc_memory.sv
// little-endian word memory, no reset of contents, no preload; misaligned or siz 3 gives err
`default_nettype none

module soc_memory
  import tcb_pkg::*;
  import soc_map_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     vld,
  input  wire tcb_req_t req,
  output tcb_rsp_t      rsp
);

  // storage
  dat_t mem [0:2**MEM_ADR-1];

  logic [MEM_ADR-1:0] widx;
  logic [1:0]         lane;
  ben_t               ben;
  logic               mis;
  dat_t               wsh;
  dat_t               rsh;
  dat_t               rdm;

  assign widx = req.adr[MEM_ADR+1:2];
  assign lane = req.adr[1:0];

  ////////////////////////////////////////////////////////////////////////////
  // size to byte enable conversion
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req.siz)
      SIZ_B: begin
        ben = ben_t'(4'b0001 << lane);
        mis = 1'b0;
      end
      SIZ_H: begin
        ben = ben_t'(4'b0011 << lane);
        // half word must sit on an even address
        mis = lane[0];
      end
      SIZ_W: begin
        ben = 4'b1111;
        mis = |lane;
      end
      default: begin
        // illegal size
        ben = 4'b0000;
        mis = 1'b1;
      end
    endcase
  end

  // low bytes of wdt moved onto the addressed lanes
  assign wsh = wdt_shift(req.wdt, lane);

  function automatic dat_t wdt_shift(input dat_t d, input logic [1:0] l);
    return d << {l, 3'b000};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // write
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (vld && req.wen && !mis) begin
      for (int b = 0; b < 4; b++) begin
        if (ben[b]) begin
          mem[widx][8*b +: 8] <= wsh[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read
  ////////////////////////////////////////////////////////////////////////////

  // addressed bytes right-aligned
  assign rsh = mem[widx] >> {lane, 3'b000};

  // zero extension to size
  always_comb begin
    case (req.siz)
      SIZ_B:   rdm = {24'h0, rsh[7:0]};
      SIZ_H:   rdm = {16'h0, rsh[15:0]};
      default: rdm = rsh;
    endcase
  end

  // old word is read, writes and errors return zero
  always_ff @(posedge clk) begin
    if (vld) begin
      rsp.err <= mis;
      rsp.rdt <= (mis || req.wen) ? '0 : rdm;
    end
  end

  // a strobed address must be fully known
  assert property (@(posedge clk) vld |-> !$isunknown(req.adr));

endmodule : soc_memory

`default_nettype wire

//--- run.sh
#!/bin/sh
# build with Verilator, run, then decide from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module soc_tb -f compile.f \
  && ./obj_dir/Vsoc_tb 2>&1 | tee sim.log
# a missing or incomplete log counts as failure
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0

//--- verif/soc_tb.sv
// stands in for the core on the manager port; relies on the fixed one-cycle response latency
`default_nettype none

module soc_tb
  import tcb_pkg::*;
  import soc_map_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  // one table row: request, pin input and what must come back a cycle later
  typedef struct packed {
    logic     vld;
    tcb_req_t req;
    gpio_t    gi;
    tcb_rsp_t rsp;
    gpio_t    gpo;
    gpio_t    gpe;
  } step_t;

  localparam adr_t  M  = MEM_BASE;
  localparam adr_t  G  = GPIO_BASE;
  localparam gpio_t O1 = 32'hA5A5_0F0F;
  localparam gpio_t E1 = 32'h0000_FFFF;
  localparam gpio_t GI = 32'h1234_5678;

  logic     clk;
  logic     rst_n;
  logic     vld;
  tcb_req_t req;
  tcb_rsp_t rsp;
  logic     rsp_vld;
  gpio_t    gpio_i;
  gpio_t    gpio_o;
  gpio_t    gpio_e;

  step_t  tab [$];
  // step whose response is due next
  step_t  pend;
  dat_t   model [0:(1 << MEM_ADR) - 1];
  integer seed = 32'h9ffc;

  soc_top soc_top_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (vld),
    .req     (req),
    .rsp     (rsp),
    .rsp_vld (rsp_vld),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o),
    .gpio_e  (gpio_e)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic end_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_rsp(input tcb_rsp_t got, input tcb_rsp_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: rsp got rdt=%h err=%b, expected rdt=%h err=%b",
               $time, got.rdt, got.err, exp.rdt, exp.err);
      end_with_failure();
    end
  endtask

  task automatic check_gpio(input string name, input gpio_t got, input gpio_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_vld(input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: rsp_vld got %b, expected %b", $time, got, exp);
      end_with_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic step_t make_step(input logic v, input logic w, input adr_t a,
                                      input siz_t s, input dat_t d, input gpio_t gi,
                                      input dat_t erdt, input logic eerr,
                                      input gpio_t eo, input gpio_t ee);
    step_t st;
    st.vld     = v;
    st.req.wen = w;
    st.req.adr = a;
    st.req.siz = s;
    st.req.wdt = d;
    st.gi      = gi;
    st.rsp.rdt = erdt;
    st.rsp.err = eerr;
    st.gpo     = eo;
    st.gpe     = ee;
    return st;
  endfunction

  // checks the step issued last cycle, then drives the new one
  task automatic apply_step(input step_t s);
    @(posedge clk);
    #1;
    check_vld(rsp_vld, pend.vld);
    if (pend.vld) begin
      check_rsp(rsp, pend.rsp);
    end
    check_gpio("gpio_o", gpio_o, pend.gpo);
    check_gpio("gpio_e", gpio_e, pend.gpe);
    vld    = s.vld;
    req    = s.req;
    gpio_i = s.gi;
    pend   = s;
  endtask

  task automatic build_table();
    // word write and read back, then lane writes
    tab.push_back(make_step(1'b1, 1'b1, M + 'h10, SIZ_W, 32'h1122_3344, '0, '0, 1'b0, '0, '0));
    tab.push_back(make_step(1'b1, 1'b0, M + 'h10, SIZ_W, '0, '0, 32'h1122_3344, 1'b0, '0, '0));
    tab.push_back(make_step(1'b1, 1'b1, M + 'h11, SIZ_B, 32'hFFFF_FFAA, '0, '0, 1'b0, '0, '0));
    tab.push_back(make_step(1'b1, 1'b1, M + 'h12, SIZ_H, 32'hEEEE_BEEF, '0, '0, 1'b0, '0, '0));
    tab.push_back(make_step(1'b1, 1'b0, M + 'h10, SIZ_W, '0, '0, 32'hBEEF_AA44, 1'b0, '0, '0));
    // sized reads, right aligned and zero extended
    tab.push_back(make_step(1'b1, 1'b0, M + 'h11, SIZ_B, '0, '0, 32'h0000_00AA, 1'b0, '0, '0));
    tab.push_back(make_step(1'b1, 1'b0, M + 'h13, SIZ_B, '0, '0, 32'h0000_00BE, 1'b0, '0, '0));
    tab.push_back(make_step(1'b1, 1'b0, M + 'h12, SIZ_H, '0, '0, 32'h0000_BEEF, 1'b0, '0, '0));
    tab.push_back(make_step(1'b1, 1'b0, M + 'h10, SIZ_H, '0, '0, 32'h0000_AA44, 1'b0, '0, '0));
    // misaligned and siz 3, word must stay as it was
    tab.push_back(make_step(1'b1, 1'b1, M + 'h12, SIZ_W, '0, '0, '0, 1'b1, '0, '0));
    tab.push_back(make_step(1'b1, 1'b1, M + 'h11, SIZ_H, '0, '0, '0, 1'b1, '0, '0));
    tab.push_back(make_step(1'b1, 1'b1, M + 'h10, 2'd3, '0, '0, '0, 1'b1, '0, '0));
    tab.push_back(make_step(1'b1, 1'b0, M + 'h13, SIZ_W, '0, '0, '0, 1'b1, '0, '0));
    tab.push_back(make_step(1'b1, 1'b0, M + 'h10, SIZ_W, '0, '0, 32'hBEEF_AA44, 1'b0, '0, '0));
    // GPIO registers
    tab.push_back(make_step(1'b1, 1'b1, G + GPIO_OUT, SIZ_W, O1, '0, '0, 1'b0, O1, '0));
    tab.push_back(make_step(1'b1, 1'b1, G + GPIO_ENA, SIZ_W, E1, '0, '0, 1'b0, O1, E1));
    tab.push_back(make_step(1'b1, 1'b0, G + GPIO_OUT, SIZ_W, '0, '0, O1, 1'b0, O1, E1));
    tab.push_back(make_step(1'b1, 1'b0, G + GPIO_ENA, SIZ_W, '0, '0, E1, 1'b0, O1, E1));
    // byte access, bad offset, ignored write to INP
    tab.push_back(make_step(1'b1, 1'b1, G + GPIO_OUT, SIZ_B, '0, '0, '0, 1'b1, O1, E1));
    tab.push_back(make_step(1'b1, 1'b1, G + 'hC, SIZ_W, '0, '0, '0, 1'b1, O1, E1));
    tab.push_back(make_step(1'b1, 1'b1, G + GPIO_INP, SIZ_W, '1, '0, '0, 1'b0, O1, E1));
    // input held through the synchronizer, then read
    tab.push_back(make_step(1'b0, 1'b0, '0, SIZ_W, '0, GI, '0, 1'b0, O1, E1));
    tab.push_back(make_step(1'b0, 1'b0, '0, SIZ_W, '0, GI, '0, 1'b0, O1, E1));
    tab.push_back(make_step(1'b0, 1'b0, '0, SIZ_W, '0, GI, '0, 1'b0, O1, E1));
    tab.push_back(make_step(1'b1, 1'b0, G + GPIO_INP, SIZ_W, '0, GI, GI, 1'b0, O1, E1));
    // unmapped space
    tab.push_back(make_step(1'b1, 1'b0, 32'h0000_1000, SIZ_W, '0, '0, '0, 1'b1, O1, E1));
    tab.push_back(make_step(1'b1, 1'b1, G + 'h40, SIZ_W, '1, '0, '0, 1'b1, O1, E1));
    tab.push_back(make_step(1'b1, 1'b0, M + 'h1000, SIZ_W, '0, '0, '0, 1'b1, O1, E1));
  endtask

  // random words to random aligned addresses, then read back
  task automatic random_phase();
    adr_t adr_q [$];
    int   idx;
    dat_t d;
    adr_t a;
    for (int i = 0; i < 64; i++) begin
      idx = $random(seed) & ((1 << MEM_ADR) - 1);
      d   = $random(seed);
      a   = M + adr_t'(idx << 2);
      model[idx] = d;
      adr_q.push_back(a);
      apply_step(make_step(1'b1, 1'b1, a, SIZ_W, d, '0, '0, 1'b0, O1, E1));
    end
    foreach (adr_q[i]) begin
      idx = int'(adr_q[i][MEM_ADR+1:2]);
      apply_step(make_step(1'b1, 1'b0, adr_q[i], SIZ_W, '0, '0, model[idx], 1'b0, O1, E1));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int limit;
    rst_n  = 1'b0;
    vld    = 1'b0;
    req    = '0;
    gpio_i = '0;
    pend   = '0;
    build_table();
    limit = (tab.size() + 64 * 2 + 50) * 4;
    fork
      begin
        #(limit);
        $display("timeout: test did not end within %0d ns", limit);
        end_with_failure();
      end
    join_none
    repeat (10) @(posedge clk);
    #1;
    // state straight out of reset
    check_vld(rsp_vld, 1'b0);
    check_gpio("gpio_o", gpio_o, '0);
    check_gpio("gpio_e", gpio_e, '0);
    rst_n = 1'b1;
    foreach (tab[i]) begin
      apply_step(tab[i]);
    end
    random_phase();
    // idle step collects the last response
    apply_step(make_step(1'b0, 1'b0, '0, SIZ_W, '0, '0, '0, 1'b0, O1, E1));
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule : soc_tb

`default_nettype wire
